//--- Makefile
TOP = cache_bank_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o sim_bin
	out=$$(./obj_dir/sim_bin); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- bank_arbiter.sv
module bank_arbiter
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       init_enable,
    input  index_t     init_line_sel,
    input  core_req_t  replay,
    input  logic       replay_valid,
    input  line_addr_t fill_addr,
    input  line_t      mem_rsp_data,
    input  logic       mem_rsp_valid,
    output logic       mem_rsp_ready,
    input  core_req_t  core_req,
    input  logic       core_req_valid,
    output logic       core_req_ready,
    input  logic       busy,
    input  logic       stall,
    input  stage_t     st1,
    output stage_t     st0
);

    logic   replay_sel;
    logic   creq_grant;
    logic   creq_ok;
    stage_t sel;

    // a replay already in flight must not be issued twice
    assign replay_sel = !init_enable && replay_valid
                     && (st0.op != op_replay) && (st1.op != op_replay);

    assign creq_grant = !init_enable && !replay_sel && !mem_rsp_valid;

    // writes wait as well, so a pending fill never misses a later write
    assign creq_ok = !busy
                  && !(st0.op == op_creq && !st0.req.rw)
                  && !(st1.op == op_creq && !st1.req.rw);

    assign mem_rsp_ready  = !init_enable && !replay_sel && !stall;
    assign core_req_ready = creq_grant && creq_ok && !stall;

    always_comb begin
        sel = '0;
        sel.op = op_none;
        if (init_enable) begin
            sel.op = op_init;
            sel.req.addr = line_addr_t'(init_line_sel);
        end else if (replay_sel) begin
            sel.op = op_replay;
            sel.req = replay;
        end else if (mem_rsp_valid) begin
            sel.op = op_fill;
            sel.req.addr = fill_addr;
            sel.fill = mem_rsp_data;
        end else if (core_req_valid && creq_ok) begin
            sel.op = op_creq;
            sel.req = core_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st0.op <= op_none;
        end else if (!stall) begin
            st0 <= sel;
        end
    end

endmodule

//--- bank_fifo.sv
module bank_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    input  logic             pop,
    output logic [WIDTH-1:0] data_out,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == (PTR_W+1)'(DEPTH));
    assign empty    = (count == '0);
    assign data_out = mem[rd_ptr];
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

//--- cache_bank.sv
module cache_bank
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter int CRSQ_DEPTH = 2,
    parameter int MREQ_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  core_req_t core_req,
    input  logic      core_req_valid,
    output logic      core_req_ready,
    output core_rsp_t core_rsp,
    output logic      core_rsp_valid,
    input  logic      core_rsp_ready,
    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    input  line_t     mem_rsp_data,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,
    input  logic      init_enable,
    input  index_t    init_line_sel
);

    stage_t     st0;
    stage_t     st1;
    word_t      read_word;
    core_req_t  replay;
    logic       replay_valid;
    line_addr_t fill_addr;
    logic       busy;
    logic       stall;
    logic       rsp_push;
    core_rsp_t  rsp_data;
    logic       rsp_full;
    logic       rsp_empty;
    logic       mreq_push;
    mem_req_t   mreq_data;
    logic       mreq_full;
    logic       mreq_empty;

    assign core_rsp_valid = !rsp_empty;
    assign mem_req_valid  = !mreq_empty;

    bank_arbiter arbiter (
        .clk            (clk),
        .rst            (rst),
        .init_enable    (init_enable),
        .init_line_sel  (init_line_sel),
        .replay         (replay),
        .replay_valid   (replay_valid),
        .fill_addr      (fill_addr),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .busy           (busy),
        .stall          (stall),
        .st1            (st1),
        .st0            (st0)
    );

    tag_store tags (
        .clk   (clk),
        .rst   (rst),
        .st0   (st0),
        .stall (stall),
        .st1   (st1)
    );

    data_store data (
        .clk       (clk),
        .st1       (st1),
        .stall     (stall),
        .read_word (read_word)
    );

    miss_unit miss (
        .clk          (clk),
        .rst          (rst),
        .st1          (st1),
        .read_word    (read_word),
        .rsp_full     (rsp_full),
        .mreq_full    (mreq_full),
        .rsp_push     (rsp_push),
        .rsp_data     (rsp_data),
        .mreq_push    (mreq_push),
        .mreq_data    (mreq_data),
        .replay       (replay),
        .replay_valid (replay_valid),
        .fill_addr    (fill_addr),
        .busy         (busy),
        .stall        (stall)
    );

    bank_fifo #(
        .WIDTH ($bits(core_rsp_t)),
        .DEPTH (CRSQ_DEPTH)
    ) rsp_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (rsp_push),
        .data_in  (rsp_data),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_out (core_rsp),
        .full     (rsp_full),
        .empty    (rsp_empty)
    );

    bank_fifo #(
        .WIDTH ($bits(mem_req_t)),
        .DEPTH (MREQ_DEPTH)
    ) mreq_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (mreq_push),
        .data_in  (mreq_data),
        .pop      (mem_req_valid && mem_req_ready),
        .data_out (mem_req),
        .full     (mreq_full),
        .empty    (mreq_empty)
    );

endmodule

//--- cache_bank_chk.sv
module cache_bank_chk
    import cache_bus_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input core_rsp_t core_rsp,
    input logic      core_rsp_valid,
    input logic      core_rsp_ready,
    input mem_req_t  mem_req,
    input logic      mem_req_valid,
    input logic      mem_req_ready,
    input logic      core_req_ready,
    input logic      init_enable
);

    timeunit 1ns;
    timeprecision 100ps;

    // a stalled response keeps its valid and its contents
    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
        else $error("core response changed while stalled");

    mreq_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request changed while stalled");

    init_blocks_core: assert property (@(posedge clk) disable iff (rst)
        init_enable |-> !core_req_ready)
        else $error("core request accepted during init");

endmodule

bind cache_bank cache_bank_chk chk (.*);

//--- cache_bank_tb.sv
module cache_bank_tb
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 300;

    logic       clk;
    logic       rst;
    core_req_t  core_req;
    logic       core_req_valid;
    logic       core_req_ready;
    core_rsp_t  core_rsp;
    logic       core_rsp_valid;
    logic       core_rsp_ready;
    mem_req_t   mem_req;
    logic       mem_req_valid;
    logic       mem_req_ready;
    line_t      mem_rsp_data;
    logic       mem_rsp_valid;
    logic       mem_rsp_ready;
    logic       init_enable;
    index_t     init_line_sel;

    word_t      mem_arr [int];
    word_t      shadow [int];
    core_rsp_t  rsp_q [$];
    time        rsp_time_q [$];
    mem_req_t   mreq_q [$];
    line_addr_t fill_q [$];
    logic       bp_on;
    int         errors;
    int         tests;
    int         passed;

    cache_bank cache_bank_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t init_word(line_addr_t a, word_sel_t w);
        return {8'hc3, 4'h0, a, 6'h00, w};
    endfunction

    function automatic word_t merge_bytes(word_t old, byteen_t be, word_t d);
        word_t r;
        r = old;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) r[8*b +: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    function automatic word_t mem_word(line_addr_t a, word_sel_t w);
        if (mem_arr.exists(int'({a, w}))) return mem_arr[int'({a, w})];
        return init_word(a, w);
    endfunction

    function automatic word_t exp_word(line_addr_t a, word_sel_t w);
        if (shadow.exists(int'({a, w}))) return shadow[int'({a, w})];
        return init_word(a, w);
    endfunction

    function automatic core_req_t make_req(line_addr_t a, logic rw, word_sel_t w,
                                           byteen_t be, word_t d, req_tag_t t);
        core_req_t r;
        r = '{addr: a, rw: rw, wsel: w, byteen: be, data: d, tag: t};
        return r;
    endfunction

    // memory model and ready generation, sampled 1 ns before the rising edge
    initial begin
        int         spell_r;
        int         spell_m;
        int         fill_wait;
        logic       fill_taken;
        line_addr_t fa;
        core_rsp_ready = 1'b1;
        mem_req_ready  = 1'b1;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        spell_r = 0;
        spell_m = 0;
        fill_wait = 1;
        fill_taken = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (!bp_on) begin
                    core_rsp_ready = 1'b1;
                    mem_req_ready  = 1'b1;
                end else begin
                    if (spell_r == 0) begin
                        core_rsp_ready = ~core_rsp_ready;
                        spell_r = int'($urandom_range(1, 5));
                    end
                    if (spell_m == 0) begin
                        mem_req_ready = ~mem_req_ready;
                        spell_m = int'($urandom_range(1, 5));
                    end
                    spell_r--;
                    spell_m--;
                end
                if (fill_taken) begin
                    mem_rsp_valid = 1'b0;
                    fill_taken = 1'b0;
                    void'(fill_q.pop_front());
                    fill_wait = int'($urandom_range(1, 6));
                end else if (!mem_rsp_valid && fill_q.size() > 0) begin
                    if (fill_wait > 1) begin
                        fill_wait--;
                    end else begin
                        fa = fill_q[0];
                        for (int w = 0; w < WORDS_PER_LINE; w++) begin
                            mem_rsp_data[w] = mem_word(fa, word_sel_t'(w));
                        end
                        mem_rsp_valid = 1'b1;
                    end
                end
                #1;
                if (core_rsp_valid && core_rsp_ready) begin
                    rsp_q.push_back(core_rsp);
                    rsp_time_q.push_back($time);
                end
                if (mem_req_valid && mem_req_ready) begin
                    mreq_q.push_back(mem_req);
                    if (mem_req.rw) begin
                        mem_arr[int'({mem_req.addr, mem_req.wsel})] = merge_bytes(
                            mem_word(mem_req.addr, mem_req.wsel), mem_req.byteen, mem_req.data);
                    end else begin
                        if (fill_q.size() == 0) fill_wait = int'($urandom_range(1, 6));
                        fill_q.push_back(mem_req.addr);
                    end
                end
                if (mem_rsp_valid && mem_rsp_ready) fill_taken = 1'b1;
            end
        end
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check_rsp(core_rsp_t got, core_rsp_t exp, string msg);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got data %h tag %h, expected data %h tag %h",
                     $time, msg, got.data, got.tag, exp.data, exp.tag);
            errors++;
        end
    endtask

    task automatic check_mreq(mem_req_t got, mem_req_t exp, string msg);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(int got, int exp, string msg);
        if (got != exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic send_req(core_req_t r, output time t);
        int n;
        @(negedge clk);
        core_req = r;
        core_req_valid = 1'b1;
        n = 0;
        #1;
        while (!core_req_ready) begin
            n++;
            if (n > TIMEOUT) abort_run("timeout: core request never accepted");
            @(negedge clk);
            #1;
        end
        t = $time;
        @(negedge clk);
        core_req_valid = 1'b0;
        // later reads of this word expect the merged bytes
        if (r.rw) begin
            shadow[int'({r.addr, r.wsel})] = merge_bytes(exp_word(r.addr, r.wsel),
                                                        r.byteen, r.data);
        end
    endtask

    task automatic wait_rsp(int n);
        int c;
        c = 0;
        while (rsp_q.size() < n) begin
            c++;
            if (c > TIMEOUT) abort_run("timeout: core response did not arrive");
            @(negedge clk);
        end
    endtask

    task automatic wait_mreq(int n);
        int c;
        c = 0;
        while (mreq_q.size() < n) begin
            c++;
            if (c > TIMEOUT) abort_run("timeout: memory request did not arrive");
            @(negedge clk);
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests++;
        if (errors == err_before) begin
            passed++;
            $display("%s: passed", name);
        end else begin
            $display("%s: failed", name);
        end
    endtask

    task automatic clear_queues();
        rsp_q.delete();
        rsp_time_q.delete();
        mreq_q.delete();
    endtask

    task automatic read_check(line_addr_t a, word_sel_t w, req_tag_t t, string msg);
        time ta;
        core_rsp_t exp;
        exp = '{data: exp_word(a, w), tag: t};
        send_req(make_req(a, 1'b0, w, '0, '0, t), ta);
        wait_rsp(rsp_q.size() + 1);
        check_rsp(rsp_q[$], exp, msg);
    endtask

    task automatic cold_miss_test();
        int e;
        e = errors;
        clear_queues();
        read_check(12'h035, 2'd1, 8'h11, "cold miss data");
        check_count(mreq_q.size(), 1, "cold miss fill count");
        check_mreq(mreq_q[0], '{rw: 1'b0, addr: 12'h035, wsel: 2'd1, byteen: '0, data: '0},
                   "cold miss fill request");
        end_test("cold read miss", e);
    endtask

    task automatic read_hit_test();
        int e;
        time t0;
        time tx;
        e = errors;
        clear_queues();
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (w == 0) begin
                send_req(make_req(12'h035, 1'b0, 2'd0, '0, '0, 8'h20), t0);
            end else begin
                send_req(make_req(12'h035, 1'b0, word_sel_t'(w), '0, '0,
                                  req_tag_t'(8'h20 + w)), tx);
            end
        end
        wait_rsp(WORDS_PER_LINE);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            check_rsp(rsp_q[w], '{data: exp_word(12'h035, word_sel_t'(w)),
                                 tag: req_tag_t'(8'h20 + w)}, "read hit data");
        end
        check_count(int'(rsp_time_q[0] - t0), 12, "read hit latency in ns");
        check_count(mreq_q.size(), 0, "read hit memory requests");
        end_test("read hit", e);
    endtask

    task automatic write_test(line_addr_t a, string name, int fills);
        int e;
        time t;
        e = errors;
        clear_queues();
        send_req(make_req(a, 1'b1, 2'd2, 4'b0101, 32'hdeadbeef, 8'h30), t);
        wait_mreq(1);
        check_mreq(mreq_q[0], '{rw: 1'b1, addr: a, wsel: 2'd2, byteen: 4'b0101,
                                data: 32'hdeadbeef}, "write-through request");
        read_check(a, 2'd2, 8'h31, "read after write");
        check_count(mreq_q.size(), 1 + fills, "memory requests after write");
        end_test(name, e);
    endtask

    task automatic init_test();
        int e;
        e = errors;
        for (int i = 0; i < NUM_LINES; i++) begin
            @(negedge clk);
            init_enable = 1'b1;
            init_line_sel = index_t'(i);
        end
        @(negedge clk);
        init_enable = 1'b0;
        clear_queues();
        read_check(12'h035, 2'd3, 8'h40, "read after flush");
        check_count(mreq_q.size(), 1, "fill requests after flush");
        end_test("init flush", e);
    endtask

    task automatic backpressure_test();
        int        e;
        int        nrd;
        time       t;
        core_req_t r;
        core_rsp_t exp_q [$];
        line_addr_t lines [4];
        e = errors;
        lines = '{12'h035, 12'h1a7, 12'h0c2, 12'h3c2};
        clear_queues();
        nrd = 0;
        bp_on = 1'b1;
        for (int i = 0; i < 24; i++) begin
            r = make_req(lines[$urandom_range(0, 3)], 1'($urandom_range(0, 1)),
                         word_sel_t'($urandom_range(0, 3)), byteen_t'($urandom_range(1, 15)),
                         word_t'($urandom()), req_tag_t'(8'h80 + i));
            if (!r.rw) begin
                exp_q.push_back('{data: exp_word(r.addr, r.wsel), tag: r.tag});
                nrd++;
            end
            send_req(r, t);
        end
        wait_rsp(nrd);
        bp_on = 1'b0;
        repeat (10) @(negedge clk);
        check_count(rsp_q.size(), nrd, "responses under back-pressure");
        for (int i = 0; i < nrd; i++) begin
            check_rsp(rsp_q[i], exp_q[i], "response under back-pressure");
        end
        end_test("back-pressure", e);
    endtask

    initial begin
        void'($urandom(76472));
        rst = 1'b1;
        core_req = '0;
        core_req_valid = 1'b0;
        init_enable = 1'b0;
        init_line_sel = '0;
        bp_on = 1'b0;
        errors = 0;
        tests = 0;
        passed = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        cold_miss_test();
        read_hit_test();
        write_test(12'h035, "write hit", 0);
        write_test(12'h1a7, "write miss", 1);
        init_test();
        backpressure_test();
        $display("tests %0d, passed %0d, errors %0d", tests, passed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- cache_bus_pkg.sv
package cache_bus_pkg;

    import cache_cfg_pkg::*;

    typedef struct packed {
        line_addr_t addr;
        logic       rw;
        word_sel_t  wsel;
        byteen_t    byteen;
        word_t      data;
        req_tag_t   tag;
    } core_req_t;

    typedef struct packed {
        word_t    data;
        req_tag_t tag;
    } core_rsp_t;

    typedef struct packed {
        logic       rw;
        line_addr_t addr;
        word_sel_t  wsel;
        byteen_t    byteen;
        word_t      data;
    } mem_req_t;

    // source of the operation held in a pipeline stage
    typedef enum logic [2:0] {
        op_none,
        op_init,
        op_replay,
        op_fill,
        op_creq
    } op_t;

    typedef struct packed {
        op_t       op;
        core_req_t req;
        line_t     fill;
        // only meaningful once the record reaches stage 1
        logic      hit;
    } stage_t;

endpackage

//--- cache_cfg_pkg.sv
package cache_cfg_pkg;

    localparam int WORD_BYTES     = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int INDEX_W        = 4;
    localparam int LINE_ADDR_W    = 12;
    localparam int TAG_W          = LINE_ADDR_W - INDEX_W;
    localparam int REQ_TAG_W      = 8;
    localparam int NUM_LINES      = 1 << INDEX_W;

    typedef logic [8*WORD_BYTES-1:0]              word_t;
    typedef word_t [WORDS_PER_LINE-1:0]           line_t;
    typedef logic [LINE_ADDR_W-1:0]               line_addr_t;
    typedef logic [INDEX_W-1:0]                   index_t;
    typedef logic [TAG_W-1:0]                     tag_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]    word_sel_t;
    typedef logic [WORD_BYTES-1:0]                byteen_t;
    typedef logic [REQ_TAG_W-1:0]                 req_tag_t;

    // index sits in the low bits of the line address
    function automatic index_t line_index(line_addr_t addr);
        return addr[INDEX_W-1:0];
    endfunction

    function automatic tag_t line_tag(line_addr_t addr);
        return addr[LINE_ADDR_W-1:INDEX_W];
    endfunction

endpackage

//--- data_store.sv
module data_store
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic   clk,
    input  stage_t st1,
    input  logic   stall,
    output word_t  read_word
);

    line_t  lines [NUM_LINES];
    index_t idx;
    line_t  cur;
    word_t  merged;
    logic   write_hit;
    logic   do_fill;

    assign idx       = line_index(st1.req.addr);
    assign cur       = lines[idx];
    assign read_word = cur[st1.req.wsel];

    assign do_fill   = (st1.op == op_fill);
    assign write_hit = (st1.op == op_creq) && st1.req.rw && st1.hit;

    // byte merge into the selected word
    always_comb begin
        merged = cur[st1.req.wsel];
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (st1.req.byteen[b]) begin
                merged[8*b +: 8] = st1.req.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (do_fill) begin
                lines[idx] <= st1.fill;
            end else if (write_hit) begin
                lines[idx][st1.req.wsel] <= merged;
            end
        end
    end

endmodule

//--- flist.f
cache_cfg_pkg.sv
cache_bus_pkg.sv
bank_fifo.sv
bank_arbiter.sv
tag_store.sv
data_store.sv
miss_unit.sv
cache_bank.sv
cache_bank_chk.sv
cache_bank_tb.sv

//--- miss_unit.sv
module miss_unit
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  stage_t     st1,
    input  word_t      read_word,
    input  logic       rsp_full,
    input  logic       mreq_full,
    output logic       rsp_push,
    output core_rsp_t  rsp_data,
    output logic       mreq_push,
    output mem_req_t   mreq_data,
    output core_req_t  replay,
    output logic       replay_valid,
    output line_addr_t fill_addr,
    output logic       busy,
    output logic       stall
);

    typedef enum logic [1:0] {
        hold_idle,
        hold_wait,
        hold_ready
    } hold_t;

    hold_t     state;
    core_req_t held;
    logic      creq_rd;
    logic      creq_wr;
    logic      rd_miss;
    logic      need_rsp;
    logic      need_mreq;

    assign creq_rd = (st1.op == op_creq) && !st1.req.rw;
    assign creq_wr = (st1.op == op_creq) && st1.req.rw;
    assign rd_miss = creq_rd && !st1.hit;

    assign need_rsp  = (creq_rd && st1.hit) || (st1.op == op_replay);
    assign need_mreq = rd_miss || creq_wr;

    assign stall     = (need_rsp && rsp_full) || (need_mreq && mreq_full);
    assign rsp_push  = need_rsp && !stall;
    assign mreq_push = need_mreq && !stall;

    assign rsp_data  = '{data: read_word, tag: st1.req.tag};
    // fill requests carry the read's fields, memory ignores them
    assign mreq_data = '{rw: st1.req.rw, addr: st1.req.addr, wsel: st1.req.wsel,
                         byteen: st1.req.byteen, data: st1.req.data};

    assign replay       = held;
    assign replay_valid = (state == hold_ready);
    assign fill_addr    = held.addr;
    assign busy         = (state != hold_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= hold_idle;
        end else if (!stall) begin
            case (state)
                hold_idle:  if (rd_miss) state <= hold_wait;
                hold_wait:  if (st1.op == op_fill) state <= hold_ready;
                hold_ready: if (st1.op == op_replay) state <= hold_idle;
                default:    state <= hold_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && state == hold_idle && rd_miss) begin
            held <= st1.req;
        end
    end

endmodule

//--- tag_store.sv
module tag_store
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  stage_t st0,
    input  logic   stall,
    output stage_t st1
);

    tag_t                 tags [NUM_LINES];
    logic [NUM_LINES-1:0] valid;
    index_t               idx;
    tag_t                 tag;
    logic                 lookup;
    stage_t               nxt;

    assign idx    = line_index(st0.req.addr);
    assign tag    = line_tag(st0.req.addr);
    assign lookup = (st0.op == op_creq) || (st0.op == op_replay);

    always_comb begin
        nxt = st0;
        nxt.hit = lookup && valid[idx] && (tags[idx] == tag);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (!stall) begin
            if (st0.op == op_fill) begin
                valid[idx] <= 1'b1;
            end else if (st0.op == op_init) begin
                valid[idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && st0.op == op_fill) begin
            tags[idx] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st1.op <= op_none;
        end else if (!stall) begin
            st1 <= nxt;
        end
    end

endmodule
